// File: testbench/soc_stim.txt
// op address data byteenable expected_read
// op 1 write, 2 read and compare, 3 wait for copy start, 0 end
1 02000000 11223344 f 00000000
1 02000004 a5a5a5a5 f 00000000
1 02000004 00c30000 4 00000000
1 02000004 123456e1 1 00000000
1 020007fc cafef00d f 00000000
1 020007fc 77889900 2 00000000
2 02000000 00000000 f 11223344
2 02000004 00000000 f a5c3a5e1
2 020007fc 00000000 f cafe990d
2 03000000 00000000 f 00000000
2 01000010 00000000 f 00000000
2 02040000 00000000 f 00000000
1 02040000 00000001 f 00000000
1 02040004 00000abc f 00000000
1 02040008 00000001 f 00000000
1 02040008 00000000 f 00000000
1 02050000 00000010 f 00000000
1 02050004 00000080 f 00000000
1 02050008 00000003 f 00000000
1 0205000c 00000001 f 00000000
3 00000000 00000000 0 00000000
1 02000100 0badcafe f 00000000
2 02000100 00000000 f 0badcafe
1 02050000 00000020 f 00000000
2 02050008 00000000 f 00000000
0 00000000 00000000 0 00000000

// File: tb.f
verilog/soc_pkg.sv
verilog/bus_decoder.sv
verilog/main_sram.sv
verilog/display_ctrl.sv
verilog/dma_regs.sv
verilog/page_copy_engine.sv
verilog/soc_fabric.sv
testbench/tb_checker.sv
testbench/tb_top.sv

// File: testbench/tb_top.sv
module tb_top;

  localparam int STIM_WORDS = 5 * 64;  // five words per stim line

  logic                            clk = 1'b0;
  logic                            reset_n;
  soc_pkg::bus_req_t               bus_req;
  soc_pkg::bus_rsp_t               bus_rsp;
  logic                            blanking;
  logic                            rd_ack;
  logic                            wr_ack;
  soc_pkg::page_cmd_t              rd_page;
  soc_pkg::page_cmd_t              wr_page;
  logic [1:0]                      vga_mode;
  logic [soc_pkg::LINE_BASE_W-1:0] line_base;
  logic                            block_display;
  logic [31:0]                     exp_rdata;  // expected data of the current read
  logic [31:0]                     stim [0:STIM_WORDS-1];
  int                              error_cnt;
  int                              check_cnt;
  int                              cycle_cnt = 0;
  int                              cycle_limit;

  soc_fabric DUT (
    .clk(clk), .reset_n(reset_n), .bus_req(bus_req), .blanking(blanking),
    .rd_ack(rd_ack), .wr_ack(wr_ack), .bus_rsp(bus_rsp), .rd_page(rd_page),
    .wr_page(wr_page), .vga_mode(vga_mode), .line_base(line_base),
    .block_display(block_display)
  );

  tb_checker u_checker (
    .clk(clk), .reset_n(reset_n), .bus_req(bus_req), .bus_rsp(bus_rsp),
    .exp_rdata(exp_rdata), .rd_page(rd_page), .wr_page(wr_page), .rd_ack(rd_ack),
    .wr_ack(wr_ack), .vga_mode(vga_mode), .line_base(line_base),
    .block_display(block_display), .error_cnt(error_cnt), .check_cnt(check_cnt)
  );

  always #20 clk = ~clk;  // 40 unit period

  task automatic end_run(input bit timed_out);
    $display("closing: %0d checks, %0d errors, timed out %0d", check_cnt, error_cnt, timed_out);
    if (!timed_out && error_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  endtask

  // holds the request until an edge without waitrequest
  task automatic bus_transfer(input logic is_read, input logic [31:0] addr,
                              input logic [31:0] data, input logic [3:0] be,
                              input logic [31:0] exp);
    bus_req.address    = addr;
    bus_req.read       = is_read;
    bus_req.write      = !is_read;
    bus_req.writedata  = data;
    bus_req.byteenable = be;
    exp_rdata          = exp;
    @(posedge clk);
    while (bus_rsp.waitrequest) @(posedge clk);
    #1;
    bus_req.read  = 1'b0;
    bus_req.write = 1'b0;
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      end_run(1'b1);
    end
  end

  initial begin : blank_gen
    blanking = 1'b0;
    forever begin
      repeat (60) @(posedge clk);
      #1 blanking = 1'b1;  // 4 cycle pulse every 64
      repeat (4) @(posedge clk);
      #1 blanking = 1'b0;
    end
  end

  // answers both page ports, 1 to 4 cycles per phase
  initial begin : ack_responder
    int         delay [2];
    logic [1:0] req_now;
    logic [1:0] ack_next;
    delay = '{0, 0};
    rd_ack = 1'b0;
    wr_ack = 1'b0;
    void'($urandom(32'he885b011));
    forever begin
      @(posedge clk);
      req_now  = {wr_page.req, rd_page.req};
      ack_next = {wr_ack, rd_ack};
      for (int i = 0; i < 2; i++) begin
        if (req_now[i] != ack_next[i]) begin  // raise or release pending
          if (delay[i] == 0) delay[i] = $urandom_range(4, 1);
          delay[i]--;
          if (delay[i] == 0) ack_next[i] = req_now[i];
        end
      end
      #1;
      rd_ack = ack_next[0];
      wr_ack = ack_next[1];
    end
  end

  initial begin : stim_driver
    int          idx;
    int          len;
    logic [31:0] addr;
    reset_n   = 1'b0;
    bus_req   = '0;
    exp_rdata = '0;
    $readmemh("testbench/soc_stim.txt", stim);
    cycle_limit = 0;
    len         = 0;
    idx         = 0;
    while (stim[5*idx] != 0) begin  // budget from the stim length and dma jobs
      addr = stim[5*idx+1];
      cycle_limit += 8;
      if (stim[5*idx] == 1 && addr[31:16] == soc_pkg::DMA_BASE) begin
        if (addr[15:2] == soc_pkg::DMA_LEN) len = stim[5*idx+2][15:0];
        if (addr[15:2] == soc_pkg::DMA_GO) cycle_limit += (len + 1) * 12 + 128;
      end
      idx++;
    end
    cycle_limit += 16;  // reset and drain
    repeat (3) @(posedge clk);
    #1 reset_n = 1'b1;
    idx = 0;
    while (stim[5*idx] != 0) begin
      case (stim[5*idx])
        1: bus_transfer(1'b0, stim[5*idx+1], stim[5*idx+2], stim[5*idx+3][3:0], '0);
        2: bus_transfer(1'b1, stim[5*idx+1], '0, 4'hf, stim[5*idx+4]);
        default: begin  // wait for the first page read of a copy
          @(posedge clk);
          while (!rd_page.req) @(posedge clk);
          #1;
        end
      endcase
      idx++;
    end
    repeat (4) @(posedge clk);
    end_run(1'b0);
  end

endmodule

// File: testbench/tb_checker.sv
module tb_checker (
  input  logic                            clk,
  input  logic                            reset_n,
  input  soc_pkg::bus_req_t               bus_req,
  input  soc_pkg::bus_rsp_t               bus_rsp,
  input  logic [31:0]                     exp_rdata,
  input  soc_pkg::page_cmd_t              rd_page,
  input  soc_pkg::page_cmd_t              wr_page,
  input  logic                            rd_ack,
  input  logic                            wr_ack,
  input  logic [1:0]                      vga_mode,
  input  logic [soc_pkg::LINE_BASE_W-1:0] line_base,
  input  logic                            block_display,
  output int                              error_cnt,
  output int                              check_cnt
);

  logic [1:0]  mode_exp;
  logic [11:0] base_exp;
  logic        sys_block_exp;
  logic [15:0] src_exp;
  logic [15:0] dst_exp;
  logic [15:0] len_exp;
  logic        job_pending;       // go written, copy not finished
  logic        copy_on;           // first page read seen, copy not finished
  logic        job_seen;          // a copy job ran during the current transfer
  int          rd_cnt;            // finished read handshakes of the job
  int          wr_cnt;
  int          wait_cnt;          // wait cycles of the current transfer
  int          exp_wait;
  logic        rd_req_q;
  logic        wr_req_q;
  logic        rd_ack_q;
  logic        wr_ack_q;
  logic [15:0] addr_hi;
  logic [13:0] ofs;

  initial begin
    error_cnt = 0;
    check_cnt = 0;
  end

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      error_cnt++;
      $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic flag(input string what);
    error_cnt++;
    $display("%s at %0t", what, $time);
  endtask

  // all dut values read here are the ones before the edge
  always @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mode_exp      = 2'd3;  // display mode out of reset
      base_exp      = '0;
      sys_block_exp = 1'b0;
      job_pending   = 1'b0;
      copy_on       = 1'b0;
      job_seen      = 1'b0;
      {rd_cnt, wr_cnt, wait_cnt} = '0;
      {rd_req_q, wr_req_q, rd_ack_q, wr_ack_q} = '0;
    end else begin
      compare("vga_mode", vga_mode, mode_exp);
      compare("line_base", line_base, base_exp);
      if (sys_block_exp || copy_on) compare("block_display", block_display, 1);
      else if (!job_pending) compare("block_display", block_display, 0);
      if ((rd_page.req || wr_page.req) && !block_display)
        flag("block_display low while a page transfer is active");
      // read port, four phase and page order
      if (rd_req_q && !rd_page.req) begin
        if (!rd_ack_q) flag("rd_page req fell before rd_ack was raised");
        rd_cnt++;
      end
      if (!rd_req_q && rd_page.req) begin
        if (rd_ack_q || wr_ack_q) flag("rd_page req rose while an ack was still high");
        if (!job_pending) flag("rd_page req rose without a DMA job");
        else copy_on = 1'b1;  // screen stays blocked from here to the end
        compare("rd_page.page", rd_page.page, 16'(src_exp + rd_cnt));
        compare("rd_page.buf_sel", rd_page.buf_sel, rd_cnt[0]);
      end
      // write port, one step behind the reads
      if (wr_req_q && !wr_page.req) begin
        if (!wr_ack_q) flag("wr_page req fell before wr_ack was raised");
        wr_cnt++;
      end
      if (!wr_req_q && wr_page.req) begin
        if (rd_ack_q || wr_ack_q) flag("wr_page req rose while an ack was still high");
        if (rd_cnt == 0) flag("wr_page req raised at step 0");
        compare("wr_page.page", wr_page.page, 16'(dst_exp + wr_cnt));
        compare("wr_page.buf_sel", wr_page.buf_sel, wr_cnt[0]);
        compare("rd_cnt at write", rd_cnt, wr_cnt + 1);
      end
      // job ends once the last read is released
      if (job_pending && rd_cnt == len_exp + 1 && !rd_ack && !wr_ack) begin
        compare("wr_page transfer count", wr_cnt, len_exp);
        job_pending = 1'b0;
        copy_on     = 1'b0;
      end
      if (bus_req.read || bus_req.write) begin
        addr_hi = bus_req.address[31:16];
        ofs     = bus_req.address[15:2];
        if (job_pending) job_seen = 1'b1;
        if (bus_rsp.waitrequest) begin
          wait_cnt++;
        end else begin
          if (addr_hi == soc_pkg::DMA_BASE) begin
            if (job_pending) flag("DMA register access finished while a copy job was running");
            else if (!job_seen && wait_cnt != 0)
              flag("DMA register access stalled while no copy job was running");
          end else begin
            exp_wait = (addr_hi == soc_pkg::SRAM_BASE && bus_req.read) ? 1 : 0;
            check_cnt++;
            if (wait_cnt != exp_wait)
              flag($sformatf("transfer at %h took %0d wait cycles instead of %0d",
                             bus_req.address, wait_cnt, exp_wait));
          end
          if (bus_req.read) compare("bus_rsp.readdata", bus_rsp.readdata, exp_rdata);
          if (bus_req.write && addr_hi == soc_pkg::DISPLAY_BASE) begin
            if (ofs == 0) mode_exp = bus_req.writedata[1:0];
            if (ofs == 1) base_exp = bus_req.writedata[11:0];
            if (ofs == 2) sys_block_exp = bus_req.writedata[0];
          end
          if (bus_req.write && addr_hi == soc_pkg::DMA_BASE) begin
            if (ofs == 0) src_exp = bus_req.writedata[15:0];
            if (ofs == 1) dst_exp = bus_req.writedata[15:0];
            if (ofs == 2) len_exp = bus_req.writedata[15:0];
            if (ofs == 3) begin  // new job, counters restart
              job_pending = 1'b1;
              rd_cnt      = 0;
              wr_cnt      = 0;
            end
          end
          wait_cnt = 0;
          job_seen = 1'b0;
        end
      end
      rd_req_q = rd_page.req;
      wr_req_q = wr_page.req;
      rd_ack_q = rd_ack;
      wr_ack_q = wr_ack;
    end
  end

endmodule

// File: verilog/soc_fabric.sv
module soc_fabric (
  input  logic                             clk,
  input  logic                             reset_n,
  input  soc_pkg::bus_req_t                bus_req,
  input  logic                             blanking,
  input  logic                             rd_ack,
  input  logic                             wr_ack,
  output soc_pkg::bus_rsp_t                bus_rsp,
  output soc_pkg::page_cmd_t               rd_page,
  output soc_pkg::page_cmd_t               wr_page,
  output logic [1:0]                       vga_mode,
  output logic [soc_pkg::LINE_BASE_W-1:0]  line_base,
  output logic                             block_display
);

  soc_pkg::bus_rsp_t               sram_rsp;
  soc_pkg::bus_rsp_t               dma_rsp;
  logic                            sram_wr;
  logic                            sram_rd;
  logic                            disp_wr;
  logic                            dma_wr;
  logic                            dma_sel;
  logic [soc_pkg::REG_OFS_W-1:0]   word_ofs;
  logic                            job_go;
  logic                            job_done;
  logic                            dma_block;
  logic [soc_pkg::PAGE_W-1:0]      src_page;
  logic [soc_pkg::PAGE_W-1:0]      dst_page;
  logic [soc_pkg::PAGE_W-1:0]      page_len;

  bus_decoder u_bus_decoder (
    .bus_req(bus_req), .sram_rsp(sram_rsp), .dma_rsp(dma_rsp), .bus_rsp(bus_rsp),
    .sram_wr(sram_wr), .sram_rd(sram_rd), .disp_wr(disp_wr), .dma_wr(dma_wr),
    .dma_sel(dma_sel), .word_ofs(word_ofs)
  );

  main_sram u_main_sram (
    .clk(clk), .reset_n(reset_n), .wr(sram_wr), .rd(sram_rd),
    .addr(word_ofs[soc_pkg::SRAM_ADDR_W-1:0]),  // address[10:2]
    .wdata(bus_req.writedata), .byteenable(bus_req.byteenable), .rsp(sram_rsp)
  );

  display_ctrl u_display_ctrl (
    .clk(clk), .reset_n(reset_n), .wr(disp_wr), .word_ofs(word_ofs),
    .wdata(bus_req.writedata), .dma_block(dma_block), .vga_mode(vga_mode),
    .line_base(line_base), .block_display(block_display)
  );

  dma_regs u_dma_regs (
    .clk(clk), .reset_n(reset_n), .wr(dma_wr), .sel(dma_sel), .word_ofs(word_ofs),
    .wdata(bus_req.writedata), .job_done(job_done), .rsp(dma_rsp), .job_go(job_go),
    .src_page(src_page), .dst_page(dst_page), .page_len(page_len)
  );

  page_copy_engine u_page_copy_engine (
    .clk(clk), .reset_n(reset_n), .blanking(blanking), .job_go(job_go),
    .src_page(src_page), .dst_page(dst_page), .page_len(page_len),
    .rd_ack(rd_ack), .wr_ack(wr_ack), .rd_page(rd_page), .wr_page(wr_page),
    .dma_block(dma_block), .job_done(job_done)
  );

endmodule

// File: verilog/page_copy_engine.sv
module page_copy_engine (
  input  logic                        clk,
  input  logic                        reset_n,
  input  logic                        blanking,
  input  logic                        job_go,
  input  logic [soc_pkg::PAGE_W-1:0]  src_page,
  input  logic [soc_pkg::PAGE_W-1:0]  dst_page,
  input  logic [soc_pkg::PAGE_W-1:0]  page_len,
  input  logic                        rd_ack,
  input  logic                        wr_ack,
  output soc_pkg::page_cmd_t          rd_page,
  output soc_pkg::page_cmd_t          wr_page,
  output logic                        dma_block,
  output logic                        job_done
);

  soc_pkg::copy_state_e        state;
  logic [1:0]                  blank_sync;  // two flop synchronizer
  logic                        blank_prev;
  logic                        blank_rise;
  logic [soc_pkg::PAGE_W-1:0]  step;        // 0 .. page_len
  logic                        acks_low;

  assign blank_rise = blank_sync[1] && !blank_prev;
  assign acks_low   = !rd_ack && !wr_ack;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      blank_sync <= '0;
      blank_prev <= 1'b0;
    end else begin
      blank_sync <= {blank_sync[0], blanking};
      blank_prev <= blank_sync[1];
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state     <= soc_pkg::COPY_IDLE;
      step      <= '0;
      rd_page   <= '0;
      wr_page   <= '0;
      dma_block <= 1'b0;
      job_done  <= 1'b0;
    end else begin
      job_done <= 1'b0;  // single cycle pulse
      case (state)
        soc_pkg::COPY_IDLE: begin
          // job_done still high here while job_go clears, so no restart
          if (job_go && !job_done && blank_rise) begin
            step            <= '0;
            rd_page.page    <= src_page;
            rd_page.buf_sel <= 1'b0;           // first read into buffer a
            wr_page.page    <= dst_page - 1'b1;  // pre-decremented, bumps before use
            wr_page.buf_sel <= 1'b1;
            dma_block       <= 1'b1;
            state           <= soc_pkg::COPY_ISSUE;
          end
        end
        soc_pkg::COPY_ISSUE: begin
          if (acks_low) begin
            rd_page.req <= 1'b1;
            wr_page.req <= (step != '0);  // buffer empty on step 0
            state       <= soc_pkg::COPY_WAIT_ACK;
          end
        end
        soc_pkg::COPY_WAIT_ACK: begin
          if (rd_ack && (wr_ack || !wr_page.req)) begin  // all active reqs answered
            rd_page.req <= 1'b0;
            wr_page.req <= 1'b0;
            state       <= soc_pkg::COPY_WAIT_RELEASE;
          end
        end
        soc_pkg::COPY_WAIT_RELEASE: begin
          if (acks_low) begin
            if (step == page_len) begin  // final write done
              dma_block <= 1'b0;
              job_done  <= 1'b1;
              state     <= soc_pkg::COPY_IDLE;
            end else begin
              step            <= step + 1'b1;
              rd_page.page    <= rd_page.page + 1'b1;
              rd_page.buf_sel <= !rd_page.buf_sel;  // ping pong
              wr_page.page    <= wr_page.page + 1'b1;
              wr_page.buf_sel <= !wr_page.buf_sel;
              state           <= soc_pkg::COPY_ISSUE;
            end
          end
        end
        default: state <= soc_pkg::COPY_IDLE;
      endcase
    end
  end

  // responder must see ack before req goes away
  a_rd_hold: assert property (@(posedge clk) disable iff (!reset_n)
    rd_page.req && !rd_ack |=> rd_page.req);
  a_wr_hold: assert property (@(posedge clk) disable iff (!reset_n)
    wr_page.req && !wr_ack |=> wr_page.req);
  a_no_wr_step0: assert property (@(posedge clk) disable iff (!reset_n)
    wr_page.req |-> (step != '0));

endmodule

// File: verilog/dma_regs.sv
module dma_regs (
  input  logic                           clk,
  input  logic                           reset_n,
  input  logic                           wr,
  input  logic                           sel,
  input  logic [soc_pkg::REG_OFS_W-1:0]  word_ofs,
  input  logic [31:0]                    wdata,
  input  logic                           job_done,
  output soc_pkg::bus_rsp_t              rsp,
  output logic                           job_go,
  output logic [soc_pkg::PAGE_W-1:0]     src_page,
  output logic [soc_pkg::PAGE_W-1:0]     dst_page,
  output logic [soc_pkg::PAGE_W-1:0]     page_len
);

  logic wr_ok;

  assign wr_ok = wr && !job_go;  // stalled writes land after the job

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      case (soc_pkg::dma_reg_e'(word_ofs))
        soc_pkg::DMA_SRC: src_page <= wdata[soc_pkg::PAGE_W-1:0];
        soc_pkg::DMA_DST: dst_page <= wdata[soc_pkg::PAGE_W-1:0];
        soc_pkg::DMA_LEN: page_len <= wdata[soc_pkg::PAGE_W-1:0];  // last step index
        default: ;  // go handled below
      endcase
    end
  end

  // job request flag, set by software, cleared by the engine
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      job_go <= 1'b0;
    end else if (job_done) begin
      job_go <= 1'b0;
    end else if (wr_ok && (word_ofs == soc_pkg::DMA_GO)) begin
      job_go <= 1'b1;  // data value ignored
    end
  end

  assign rsp.readdata    = '0;             // write only block
  assign rsp.waitrequest = sel && job_go;  // hold the master until done

endmodule

// File: verilog/display_ctrl.sv
module display_ctrl (
  input  logic                             clk,
  input  logic                             reset_n,
  input  logic                             wr,
  input  logic [soc_pkg::REG_OFS_W-1:0]    word_ofs,
  input  logic [31:0]                      wdata,
  input  logic                             dma_block,
  output logic [1:0]                       vga_mode,
  output logic [soc_pkg::LINE_BASE_W-1:0]  line_base,
  output logic                             block_display
);

  logic sys_block;  // display blocked by software

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      vga_mode  <= soc_pkg::MODE_RESET;
      line_base <= '0;
      sys_block <= 1'b0;
    end else if (wr) begin
      case (soc_pkg::disp_reg_e'(word_ofs))
        soc_pkg::DISP_MODE:      vga_mode  <= wdata[1:0];
        soc_pkg::DISP_LINE_BASE: line_base <= wdata[soc_pkg::LINE_BASE_W-1:0];
        soc_pkg::DISP_BLOCK:     sys_block <= wdata[0];
        default: ;  // other offsets ignored
      endcase
    end
  end

  // either software or a running page copy blanks the screen
  assign block_display = sys_block | dma_block;

endmodule

// File: verilog/main_sram.sv
module main_sram (
  input  logic                             clk,
  input  logic                             reset_n,
  input  logic                             wr,
  input  logic                             rd,
  input  logic [soc_pkg::SRAM_ADDR_W-1:0]  addr,
  input  logic [31:0]                      wdata,
  input  logic [3:0]                       byteenable,
  output soc_pkg::bus_rsp_t                rsp
);

  logic [31:0] mem [2**soc_pkg::SRAM_ADDR_W];  // 2 kbyte
  logic [31:0] rdata_q;
  logic        rd_ack;  // set in the wait cycle of a read
  logic        rd_wait;

  assign rd_wait = rd && !rd_ack;  // first cycle of every read stalls

  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (wr && byteenable[i]) begin
        mem[addr][8*i +: 8] <= wdata[8*i +: 8];  // lane masked write
      end
    end
    if (rd_wait) begin
      rdata_q <= mem[addr];  // registered read port
    end
  end

  // clears on the completing edge, so back to back reads each get a wait
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      rd_ack <= 1'b0;
    end else begin
      rd_ack <= rd_wait;
    end
  end

  assign rsp.readdata    = rdata_q;
  assign rsp.waitrequest = rd_wait;

  a_rd_wr_excl: assert property (@(posedge clk) disable iff (!reset_n) !(rd && wr));

endmodule

// File: verilog/bus_decoder.sv
module bus_decoder (
  input  soc_pkg::bus_req_t              bus_req,
  input  soc_pkg::bus_rsp_t              sram_rsp,
  input  soc_pkg::bus_rsp_t              dma_rsp,
  output soc_pkg::bus_rsp_t              bus_rsp,
  output logic                           sram_wr,
  output logic                           sram_rd,
  output logic                           disp_wr,
  output logic                           dma_wr,
  output logic                           dma_sel,
  output logic [soc_pkg::REG_OFS_W-1:0]  word_ofs
);

  soc_pkg::region_e region;
  logic [15:0]      addr_hi;

  assign addr_hi  = bus_req.address[31:16];                 // 64k region select
  assign word_ofs = bus_req.address[soc_pkg::REG_OFS_W+1:2];  // byte addr to word

  always_comb begin
    case (addr_hi)
      soc_pkg::SRAM_BASE:    region = soc_pkg::REGION_SRAM;
      soc_pkg::DISPLAY_BASE: region = soc_pkg::REGION_DISPLAY;
      soc_pkg::DMA_BASE:     region = soc_pkg::REGION_DMA;
      default:               region = soc_pkg::REGION_NONE;  // sdram, timer, uart, spi gone
    endcase
  end

  assign sram_wr = (region == soc_pkg::REGION_SRAM) && bus_req.write;
  assign sram_rd = (region == soc_pkg::REGION_SRAM) && bus_req.read;
  assign disp_wr = (region == soc_pkg::REGION_DISPLAY) && bus_req.write;
  assign dma_sel = (region == soc_pkg::REGION_DMA) && (bus_req.read || bus_req.write);
  assign dma_wr  = (region == soc_pkg::REGION_DMA) && bus_req.write;

  // response back to the master
  always_comb begin
    case (region)
      soc_pkg::REGION_SRAM: bus_rsp = sram_rsp;
      soc_pkg::REGION_DMA:  bus_rsp = dma_rsp;   // may stall while a copy runs
      default:              bus_rsp = '0;        // display and unmapped, zero data, no wait
    endcase
  end

  // at most one slave strobe per cycle, so the master never mixes read and write
  a_one_strobe: assert final ($onehot0({sram_wr, sram_rd, disp_wr, dma_wr}));

endmodule

// File: verilog/soc_pkg.sv
package soc_pkg;

  // address map, compared against address[31:16]
  localparam logic [15:0] SRAM_BASE    = 16'h0200;  // 512 words main ram
  localparam logic [15:0] DISPLAY_BASE = 16'h0204;  // display control regs
  localparam logic [15:0] DMA_BASE     = 16'h0205;  // page copy regs

  localparam int SRAM_ADDR_W = 9;   // sram word address
  localparam int REG_OFS_W   = 14;  // address[15:2]
  localparam int PAGE_W      = 16;  // page number and page count
  localparam int LINE_BASE_W = 12;

  localparam logic [1:0] MODE_RESET = 2'd3;  // display mode out of reset

  typedef struct packed {
    logic [31:0] address;
    logic        read;
    logic        write;
    logic [31:0] writedata;
    logic [3:0]  byteenable;
  } bus_req_t;

  typedef struct packed {
    logic [31:0] readdata;
    logic        waitrequest;
  } bus_rsp_t;

  typedef struct packed {
    logic              req;
    logic [PAGE_W-1:0] page;
    logic              buf_sel;  // 0 = buffer a, 1 = buffer b
  } page_cmd_t;

  typedef enum logic [1:0] {REGION_NONE, REGION_SRAM, REGION_DISPLAY, REGION_DMA} region_e;

  typedef enum logic [1:0] {COPY_IDLE, COPY_ISSUE, COPY_WAIT_ACK, COPY_WAIT_RELEASE} copy_state_e;

  typedef enum logic [REG_OFS_W-1:0] {
    DMA_SRC = 0,
    DMA_DST = 1,
    DMA_LEN = 2,
    DMA_GO  = 3
  } dma_reg_e;

  typedef enum logic [REG_OFS_W-1:0] {DISP_MODE = 0, DISP_LINE_BASE = 1, DISP_BLOCK = 2} disp_reg_e;

endpackage
